//--- run_sim.sh
#!/bin/sh
# Builds the CPU testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module cpu_tb -f src.f -o cpu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- src.f
src/isa_pkg.sv
src/ctrl_pkg.sv
src/pc_counter.sv
src/reg_file.sv
src/exec_unit.sv
src/control_fsm.sv
src/cpu_top.sv
tests/cpu_tb.sv

//--- src/control_fsm.sv
`timescale 1ns/10ps

module control_fsm
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  data_t      instr_data,
    input  flags_t     flags,
    output ctrl_word_t ctrl,
    output reg_addr_t  rd_a_addr,
    output reg_addr_t  rd_b_addr,
    output logic       pc_inc,
    output logic       pc_load,
    output logic       imm_ld,
    output logic       hlt
);

    cpu_state_e state;
    cpu_state_e state_next;
    instr_u     ir;
    instr_u     fetched;
    logic       taken;

    assign fetched = instr_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            ir    <= '0;
        end else begin
            state <= state_next;
            if (state == DECODE) begin
                ir <= fetched;
            end
        end
    end

    always_comb begin
        case (state)
            FETCH:     state_next = DECODE;
            DECODE:    state_next = (fetched.alu.opcode == OP_LDM) ? IMM_FETCH : EXECUTE;
            IMM_FETCH: state_next = IMM_LOAD;
            IMM_LOAD:  state_next = EXECUTE;
            EXECUTE:   state_next = (ir.alu.opcode == OP_HLT) ? HALTED : FETCH;
            HALTED:    state_next = HALTED;
            default:   state_next = FETCH;
        endcase
    end

    // Branch condition against the current flags
    always_comb begin
        case (ir.jmp.cond)
            COND_JZ: taken = flags.z;
            COND_JN: taken = flags.n;
            COND_JC: taken = flags.c;
            default: taken = 1'b1;
        endcase
    end

    always_comb begin
        ctrl    = '0;
        pc_load = 1'b0;
        if (state == EXECUTE) begin
            ctrl.wr_addr = ir.alu.ra;
            case (ir.alu.opcode)
                OP_MOV: ctrl.reg_we = 1'b1;
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_INC: begin
                    ctrl.reg_we   = 1'b1;
                    ctrl.flags_we = 1'b1;
                    case (ir.alu.opcode)
                        OP_ADD:  ctrl.alu_op = ALU_ADD;
                        OP_SUB:  ctrl.alu_op = ALU_SUB;
                        OP_AND:  ctrl.alu_op = ALU_AND;
                        OP_OR:   ctrl.alu_op = ALU_OR;
                        OP_NOT:  ctrl.alu_op = ALU_NOT;
                        default: ctrl.alu_op = ALU_INC;
                    endcase
                end
                OP_IN: begin
                    ctrl.reg_we = 1'b1;
                    ctrl.b_src  = B_IN;
                end
                OP_OUT: ctrl.out_ld = 1'b1;
                OP_LDM: begin
                    ctrl.reg_we = 1'b1;
                    ctrl.b_src  = B_IMM;
                end
                OP_JMP: pc_load = taken;
                OP_SETC, OP_CLRC: begin
                    ctrl.alu_op   = ALU_CARRY;
                    ctrl.flags_we = 1'b1;
                    ctrl.carry_op = (ir.alu.opcode == OP_SETC);
                end
                default: ;
            endcase
        end
    end

    assign rd_a_addr = ir.alu.ra;
    assign rd_b_addr = ir.alu.rb;
    assign pc_inc    = (state == DECODE) || (state == IMM_LOAD);
    assign imm_ld    = (state == IMM_LOAD);
    assign hlt       = (state == HALTED);

endmodule

//--- src/cpu_top.sv
`timescale 1ns/10ps

module cpu_top
    import isa_pkg::*;
    import ctrl_pkg::*;
#(
    parameter data_t RESET_VECTOR = 8'h00
) (
    input  logic  clk,
    input  logic  rst,
    input  data_t in_port,
    input  data_t instr_data,
    output data_t instr_addr,
    output data_t out_port,
    output logic  out_valid,
    output logic  hlt
);

    ctrl_word_t ctrl;
    reg_addr_t  rd_a_addr;
    reg_addr_t  rd_b_addr;
    logic       pc_inc;
    logic       pc_load;
    logic       imm_ld;
    flags_t     flags;
    data_t      rd_a;
    data_t      rd_b;
    data_t      result;

    control_fsm control_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .instr_data (instr_data),
        .flags      (flags),
        .ctrl       (ctrl),
        .rd_a_addr  (rd_a_addr),
        .rd_b_addr  (rd_b_addr),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .imm_ld     (imm_ld),
        .hlt        (hlt)
    );

    // Jump target comes from read port B
    pc_counter #(
        .RESET_VECTOR (RESET_VECTOR)
    ) pc_counter_inst (
        .clk        (clk),
        .rst        (rst),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .load_value (rd_b),
        .pc         (instr_addr)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst       (rst),
        .rd_a_addr (rd_a_addr),
        .rd_b_addr (rd_b_addr),
        .we        (ctrl.reg_we),
        .wr_addr   (ctrl.wr_addr),
        .wr_data   (result),
        .rd_a      (rd_a),
        .rd_b      (rd_b)
    );

    exec_unit exec_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .imm_ld     (imm_ld),
        .instr_data (instr_data),
        .in_port    (in_port),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .result     (result),
        .flags      (flags),
        .out_port   (out_port),
        .out_valid  (out_valid)
    );

endmodule

//--- src/ctrl_pkg.sv
package ctrl_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        IMM_FETCH,
        IMM_LOAD,
        EXECUTE,
        HALTED
    } cpu_state_e;

    typedef enum logic [1:0] {
        B_REG = 2'd0,
        B_IMM = 2'd1,
        B_IN  = 2'd2
    } b_src_e;

    typedef enum logic [2:0] {
        ALU_PASS  = 3'd0,
        ALU_ADD   = 3'd1,
        ALU_SUB   = 3'd2,
        ALU_AND   = 3'd3,
        ALU_OR    = 3'd4,
        ALU_NOT   = 3'd5,
        ALU_INC   = 3'd6,
        ALU_CARRY = 3'd7
    } alu_op_e;

    // All zero means no side effect
    typedef struct packed {
        logic      reg_we;
        reg_addr_t wr_addr;
        b_src_e    b_src;
        alu_op_e   alu_op;
        logic      flags_we;
        logic      carry_op;
        logic      out_ld;
    } ctrl_word_t;

endpackage

//--- src/exec_unit.sv
`timescale 1ns/10ps

module exec_unit
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  ctrl_word_t ctrl,
    input  logic       imm_ld,
    input  data_t      instr_data,
    input  data_t      in_port,
    input  data_t      rd_a,
    input  data_t      rd_b,
    output data_t      result,
    output flags_t     flags,
    output data_t      out_port,
    output logic       out_valid
);

    data_t      imm_q;
    data_t      operand_b;
    flags_t     flags_q;
    flags_t     flags_next;
    logic [8:0] wide;

    always_ff @(posedge clk) begin
        if (imm_ld) begin
            imm_q <= instr_data;
        end
    end

    always_comb begin
        case (ctrl.b_src)
            B_IMM:   operand_b = imm_q;
            B_IN:    operand_b = in_port;
            default: operand_b = rd_b;
        endcase
    end

    always_comb begin
        wide       = '0;
        result     = operand_b;
        flags_next = flags_q;
        case (ctrl.alu_op)
            ALU_ADD: begin
                wide         = {1'b0, rd_a} + {1'b0, operand_b};
                result       = wide[7:0];
                flags_next.c = wide[8];
                flags_next.v = (rd_a[7] == operand_b[7]) && (result[7] != rd_a[7]);
            end
            ALU_SUB: begin
                // Bit 8 set means borrow
                wide         = {1'b0, rd_a} - {1'b0, operand_b};
                result       = wide[7:0];
                flags_next.c = wide[8];
                flags_next.v = (rd_a[7] != operand_b[7]) && (result[7] != rd_a[7]);
            end
            ALU_INC: begin
                wide         = {1'b0, rd_a} + 9'd1;
                result       = wide[7:0];
                flags_next.c = wide[8];
                flags_next.v = !rd_a[7] && result[7];
            end
            ALU_AND:   result = rd_a & operand_b;
            ALU_OR:    result = rd_a | operand_b;
            ALU_NOT:   result = ~operand_b;
            ALU_CARRY: flags_next.c = ctrl.carry_op;
            default: ;
        endcase
        if (ctrl.alu_op != ALU_CARRY && ctrl.alu_op != ALU_PASS) begin
            flags_next.z = (result == 8'h00);
            flags_next.n = result[7];
        end
    end

    // Condition-code register
    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '0;
        end else if (ctrl.flags_we) begin
            flags_q <= flags_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_port  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctrl.out_ld;
            if (ctrl.out_ld) begin
                out_port <= rd_b;
            end
        end
    end

    assign flags = flags_q;

endmodule

//--- src/isa_pkg.sv
package isa_pkg;

    typedef logic [7:0] data_t;
    typedef logic [1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_MOV  = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_NOT  = 4'h6,
        OP_INC  = 4'h7,
        OP_IN   = 4'h8,
        OP_OUT  = 4'h9,
        OP_LDM  = 4'hA,
        OP_JMP  = 4'hB,
        OP_SETC = 4'hC,
        OP_CLRC = 4'hD,
        OP_RSVD = 4'hE,
        OP_HLT  = 4'hF
    } opcode_e;

    // Condition field of the jump family in bits 3:2
    typedef enum logic [1:0] {
        COND_JZ  = 2'd0,
        COND_JN  = 2'd1,
        COND_JC  = 2'd2,
        COND_JMP = 2'd3
    } jump_cond_e;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t ra;
        reg_addr_t rb;
    } alu_fmt_t;

    typedef struct packed {
        opcode_e    opcode;
        jump_cond_e cond;
        reg_addr_t  rb;
    } jump_fmt_t;

    typedef union packed {
        alu_fmt_t  alu;
        jump_fmt_t jmp;
    } instr_u;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

endpackage

//--- src/pc_counter.sv
`timescale 1ns/10ps

module pc_counter
    import isa_pkg::*;
#(
    parameter data_t RESET_VECTOR = 8'h00
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  pc_inc,
    input  logic  pc_load,
    input  data_t load_value,
    output data_t pc
);

    // Load wins over increment and the count wraps past 255
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VECTOR;
        end else if (pc_load) begin
            pc <= load_value;
        end else if (pc_inc) begin
            pc <= pc + 8'd1;
        end
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/10ps

module reg_file
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rd_a_addr,
    input  reg_addr_t rd_b_addr,
    input  logic      we,
    input  reg_addr_t wr_addr,
    input  data_t     wr_data,
    output data_t     rd_a,
    output data_t     rd_b
);

    data_t regs [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see the old value during a write cycle
    assign rd_a = regs[rd_a_addr];
    assign rd_b = regs[rd_b_addr];

endmodule

//--- tests/cpu_cases.txt
# Per case: name and in_port value, then program bytes in hex ending with HLT,
# then the expected out_port bytes in order
arith 00
A0 25 A4 13 21 90 31 90 A8 F0 AC 20 2B 92 34 91 F0
38 25 10 EE
logic 00
A0 CA A4 0F 18 49 92 1C 5D 93 61 90 74 91 11 90 F0
0A CF F0 10 10
in_port 5A
8C 93 80 70 90 F0
5A 5B
branch 00
A0 05 A4 05 A8 09 31 B2 91 90 A0 03 A8 11 21 B6 90 A0 FF A8 18 21 BA 91 90 D0 A8 1E BA 91 F0
00 08 04 05
loop 00
A0 04 A4 01 A8 0C AC 08 90 31 B2 BF F0
04 03 02 01
carry_nop 00
A0 FF 70 90 D0 C0 E0 00 A8 0C BA 91 74 91 F0
00 01

//--- tests/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb
    import isa_pkg::*;
();

    localparam data_t RESET_VECTOR = 8'h00;
    localparam int    HOLD_CYCLES  = 10;

    logic  clk;
    logic  rst;
    data_t in_port;
    data_t instr_data;
    data_t instr_addr;
    data_t out_port;
    logic  out_valid;
    logic  hlt;

    data_t rom_mem [256];
    data_t addr_q;

    // Case table, program and expected bytes flattened
    string case_name [$];
    data_t case_in [$];
    int    prog_start [$];
    int    prog_len [$];
    int    exp_start [$];
    int    exp_count [$];
    data_t prog_bytes [$];
    data_t exp_bytes [$];
    data_t tokens [$];

    int    cur;
    logic  watching;
    int    first_out;
    int    out_count;
    int    value_errors;
    int    count_errors;
    int    other_errors;
    int    cycles;
    int    cycle_limit;

    cpu_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) cpu_top_inst (
        .clk        (clk),
        .rst        (rst),
        .in_port    (in_port),
        .instr_data (instr_data),
        .instr_addr (instr_addr),
        .out_port   (out_port),
        .out_valid  (out_valid),
        .hlt        (hlt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

    // Synchronous ROM returns the sampled address's byte just after the edge
    initial begin
        addr_q = RESET_VECTOR;
        forever begin
            @(negedge clk);
            addr_q = instr_addr;
        end
    end

    initial begin
        instr_data = '0;
        forever begin
            @(posedge clk);
            #1;
            instr_data = rom_mem[addr_q];
        end
    end

    initial begin
        while (cycle_limit == 0 || cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: %0d cycles passed and the tests did not finish", cycles);
        $display("Something failed");
        $finish;
    end

    // One output per out_valid pulse
    initial begin
        forever begin
            @(negedge clk);
            if (watching && out_valid) begin
                if (out_count - first_out < exp_count[cur]) begin
                    check_out(case_name[cur],
                              exp_bytes[exp_start[cur] + out_count - first_out], out_port);
                end
                out_count++;
            end
        end
    end

    task automatic check_out(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("error %s: out_port expected %02h, actual %02h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("error %s: output count expected %0d, actual %0d", name, expected, actual);
            count_errors++;
        end
    endtask

    function automatic int hex_digit(input logic [7:0] c);
        if (c >= 8'h30 && c <= 8'h39) begin
            return int'(c) - 48;
        end else if (c >= 8'h61 && c <= 8'h66) begin
            return int'(c) - 87;
        end else if (c >= 8'h41 && c <= 8'h46) begin
            return int'(c) - 55;
        end
        return -1;
    endfunction

    task automatic parse_hex(input string line);
        int   val;
        int   d;
        logic in_tok;
        val = 0;
        in_tok = 1'b0;
        tokens.delete();
        for (int i = 0; i <= line.len(); i++) begin
            d = (i < line.len()) ? hex_digit(line.getc(i)) : -1;
            if (d >= 0) begin
                val = val * 16 + d;
                in_tok = 1'b1;
            end else if (in_tok) begin
                tokens.push_back(val[7:0]);
                val = 0;
                in_tok = 1'b0;
            end
        end
    endtask

    task automatic read_cases();
        int    fd;
        int    field;
        int    in_val;
        string line;
        string name;
        field = 0;
        fd = $fopen("tests/cpu_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/cpu_cases.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comment lines (#) and blank lines
            if (line.len() == 0 || line.getc(0) == 8'h23 || line.getc(0) == 8'h0a) begin
                continue;
            end
            if (field == 0) begin
                if ($sscanf(line, "%s %h", name, in_val) != 2) begin
                    $display("Case header line could not be read: %s", line);
                    other_errors++;
                end
                case_name.push_back(name);
                case_in.push_back(in_val[7:0]);
            end else if (field == 1) begin
                parse_hex(line);
                prog_start.push_back(prog_bytes.size());
                prog_len.push_back(tokens.size());
                foreach (tokens[t]) begin
                    prog_bytes.push_back(tokens[t]);
                end
            end else begin
                parse_hex(line);
                exp_start.push_back(exp_bytes.size());
                exp_count.push_back(tokens.size());
                foreach (tokens[t]) begin
                    exp_bytes.push_back(tokens[t]);
                end
            end
            field = (field + 1) % 3;
        end
        $fclose(fd);
        if (field != 0) begin
            $display("The case file ends in the middle of a case");
            other_errors++;
        end
        if (exp_count.size() == 0) begin
            $display("No complete case was found in the case file");
            other_errors++;
        end
    endtask

    // A loop pass emits one output, so outputs stand in for passes
    function automatic int case_budget(input int idx);
        return 5 * prog_len[idx] + 40 * exp_count[idx];
    endfunction

    task automatic run_case(input int idx);
        data_t addr;
        data_t halt_addr;
        int    waited;
        @(posedge clk);
        #1;
        rst = 1'b1;
        watching = 1'b0;
        in_port = case_in[idx];
        addr = '0;
        repeat (256) begin
            // HLT opcode with the whole address folded into the low nibble
            rom_mem[addr] = {4'hF, addr[7:4] ^ addr[3:0]};
            addr = addr + 8'd1;
        end
        addr = RESET_VECTOR;
        for (int i = 0; i < prog_len[idx]; i++) begin
            rom_mem[addr] = prog_bytes[prog_start[idx] + i];
            addr = addr + 8'd1;
        end
        cur = idx;
        first_out = out_count;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        watching = 1'b1;
        waited = 0;
        while (!hlt && waited < case_budget(idx)) begin
            @(negedge clk);
            waited++;
        end
        if (!hlt) begin
            $display("Case %s did not halt within %0d cycles", case_name[idx], waited);
            other_errors++;
        end else begin
            halt_addr = instr_addr;
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                if (!hlt || instr_addr !== halt_addr || out_valid) begin
                    $display("Case %s left the halted state: hlt %b, pc %02h, out_valid %b",
                             case_name[idx], hlt, instr_addr, out_valid);
                    other_errors++;
                end
            end
        end
        @(posedge clk);
        check_count(case_name[idx], exp_count[idx], out_count - first_out);
        watching = 1'b0;
    endtask

    initial begin
        int total;
        rst = 1'b1;
        in_port = '0;
        watching = 1'b0;
        cur = 0;
        read_cases();
        total = 50;
        for (int k = 0; k < exp_count.size(); k++) begin
            total += case_budget(k) + 8 + HOLD_CYCLES + 2;
        end
        cycle_limit = total;
        for (int k = 0; k < exp_count.size(); k++) begin
            run_case(k);
        end
        $display("Errors: %0d wrong outputs, %0d wrong counts, %0d other",
                 value_errors, count_errors, other_errors);
        if (value_errors + count_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
